// ==== bench/mult_input.txt ====
# mult_sub multiplicand(33b) multiplier(33b) mult_round(32b) expected(66b), all hex
# expected = +/-(multiplicand * multiplier) + mult_round, mod 2^66
0 000000000 000000000 00000000 00000000000000000
0 000000001 000000001 00000000 00000000000000001
0 1FFFFFFFF 000000001 00000000 3FFFFFFFFFFFFFFFF
0 1FFFFFFFF 1FFFFFFFF 00000000 00000000000000001
0 07FFFFFFF 07FFFFFFF 00000000 03FFFFFFF00000001
0 180000000 180000000 00000000 04000000000000000
0 180000000 07FFFFFFF 00000000 3C000000080000000
0 0FFFFFFFF 0FFFFFFFF 00000000 0FFFFFFFE00000001
0 0FFFFFFFF 1FFFFFFFF 00000000 3FFFFFFFF00000001
0 012345678 000000010 00000000 00000000123456780
1 000000003 000000005 00000000 3FFFFFFFFFFFFFFF1
1 1FFFFFFFF 000000007 00000000 00000000000000007
1 180000000 180000000 00000000 3C000000000000000
0 000000002 000000003 FFFFFFFF 00000000100000005
1 000000002 000000003 00000010 0000000000000000A
1 000000000 000000000 FFFFFFFF 000000000FFFFFFFF
0 1FFFFFFFF 1FFFFFFFF 80000000 00000000080000001

// ==== build.f ====
logic/booth_mult_pkg.sv
logic/ex1_rows_if.sv
logic/compress_4to2.sv
logic/booth_digit_enc.sv
logic/booth_pp_gen.sv
logic/ex1_tree.sv
logic/ex2_tree.sv
logic/booth_mult_top.sv
bench/tb_booth_mult.sv

// ==== Bender.yml ====
package:
  name: booth_mult

sources:
  - logic/booth_mult_pkg.sv
  - logic/ex1_rows_if.sv
  - logic/compress_4to2.sv
  - logic/booth_digit_enc.sv
  - logic/booth_pp_gen.sv
  - logic/ex1_tree.sv
  - logic/ex2_tree.sv
  - logic/booth_mult_top.sv
  - target: test
    files:
      - bench/tb_booth_mult.sv

// ==== bench/tb_booth_mult.sv ====
// Booth MAC testbench
`timescale 1ns/1ps
`default_nettype none

module tb_booth_mult
  import booth_mult_pkg::*;
();

  localparam int RESET_CYCLES = 5;
  localparam int RAND_COUNT   = 200;
  localparam int MAX_VECTORS  = 64;
  localparam int MARGIN       = 20;

  // starts low before any process runs, so time 0 has no clock edge
  logic   clk = 1'b0;
  logic   reset;
  logic   in_vld;
  logic   mult_sub;
  round_t mult_round;
  src_t   multiplicand;
  src_t   multiplier;
  logic   out_vld;
  res_t   result_0;
  res_t   result_1;

  // expected results, oldest first
  dst_t exp_q [$];
  // in_vld delayed by the pipeline depth
  logic [LAT_CYCLES-1:0] vld_pipe;

  int mismatch_count;
  int other_count;
  int cycle_count;
  int cycle_limit;

  // directed vectors from the data file
  logic   dir_sub [MAX_VECTORS];
  src_t   dir_a   [MAX_VECTORS];
  src_t   dir_b   [MAX_VECTORS];
  round_t dir_rnd [MAX_VECTORS];
  dst_t   dir_exp [MAX_VECTORS];

  booth_mult_top dut_i (
    .clk          (clk),
    .reset        (reset),
    .in_vld       (in_vld),
    .mult_sub     (mult_sub),
    .mult_round   (mult_round),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .out_vld      (out_vld),
    .result_0     (result_0),
    .result_1     (result_1)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ==================================================
  // reference model and compare tasks
  // ==================================================

  // signed product, negated in subtract mode, plus unsigned round, mod 2^66
  function automatic dst_t model_result(input logic sub, input src_t a, input src_t b,
                                        input round_t rnd);
    logic signed [DST_WIDTH-1:0] a_ext;
    logic signed [DST_WIDTH-1:0] b_ext;
    logic signed [DST_WIDTH-1:0] prod;
    a_ext = {{(DST_WIDTH-SRC_WIDTH){a[SRC_WIDTH-1]}}, a};
    b_ext = {{(DST_WIDTH-SRC_WIDTH){b[SRC_WIDTH-1]}}, b};
    prod  = a_ext * b_ext;
    if (sub) begin
      prod = -prod;
    end
    return prod + {{(DST_WIDTH-ROUND_WIDTH){1'b0}}, rnd};
  endfunction

  // 32-bit value to operand, signed or unsigned
  function automatic src_t extend_operand(input logic [SRC_WIDTH-2:0] value,
                                          input logic is_signed);
    return {is_signed & value[SRC_WIDTH-2], value};
  endfunction

  task automatic check_dst(input string name, input dst_t actual, input dst_t expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: got %h expected %h (cycle %0d)",
               name, actual, expected, cycle_count);
    end
  endtask

  task automatic check_vld(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: got %h expected %h (cycle %0d)",
               name, actual, expected, cycle_count);
    end
  endtask

  // ==================================================
  // drivers, all on the falling edge
  // ==================================================
  task automatic drive_op(input logic sub, input src_t a, input src_t b,
                          input round_t rnd, input dst_t expected);
    @(negedge clk);
    in_vld       = 1'b1;
    mult_sub     = sub;
    multiplicand = a;
    multiplier   = b;
    mult_round   = rnd;
    exp_q.push_back(expected);
  endtask

  task automatic drive_idle();
    @(negedge clk);
    in_vld = 1'b0;
  endtask

  // ==================================================
  // monitors
  // ==================================================

  // model of the two valid stages, reset clears both
  always @(posedge clk) begin
    if (reset) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[LAT_CYCLES-2:0], in_vld};
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, results still outstanding: %0d",
               cycle_count, exp_q.size());
      $display("Done: errors found");
      $finish;
    end
  end

  // outputs are stable half a cycle after the rising edge
  always @(negedge clk) begin : result_monitor
    dst_t sum_low;
    dst_t expected;
    check_vld("out_vld", out_vld, vld_pipe[LAT_CYCLES-1]);
    if (out_vld === 1'b1) begin
      if (exp_q.size() == 0) begin
        other_count++;
        $display("out_vld high with no operation in flight (cycle %0d)", cycle_count);
      end else begin
        expected = exp_q.pop_front();
        // redundant pair resolved mod 2^66
        sum_low  = result_0[DST_WIDTH-1:0] + result_1[DST_WIDTH-1:0];
        check_dst("result_0+result_1", sum_low, expected);
      end
    end
  end

  // ==================================================
  // main sequence
  // ==================================================
  initial begin : main_seq
    int     fd;
    int     n_fields;
    int     n_dir;
    string  line;
    logic   f_sub;
    src_t   f_a;
    src_t   f_b;
    round_t f_rnd;
    dst_t   f_exp;
    logic   r_sub;
    src_t   r_a;
    src_t   r_b;
    round_t r_rnd;

    reset          = 1'b1;
    in_vld         = 1'b0;
    mult_sub       = 1'b0;
    mult_round     = '0;
    multiplicand   = '0;
    multiplier     = '0;
    vld_pipe       = '0;
    mismatch_count = 0;
    other_count    = 0;
    cycle_count    = 0;
    n_dir          = 0;
    void'($urandom(73));

    // directed vectors, # lines are comments
    fd = $fopen("bench/mult_input.txt", "r");
    if (fd == 0) begin
      other_count++;
      $display("cannot open bench/mult_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) == 0) begin
          break;
        end
        if (line.len() == 0 || line[0] == "#") begin
          continue;
        end
        n_fields = $sscanf(line, "%h %h %h %h %h", f_sub, f_a, f_b, f_rnd, f_exp);
        if (n_fields == 5 && n_dir < MAX_VECTORS) begin
          dir_sub[n_dir] = f_sub;
          dir_a[n_dir]   = f_a;
          dir_b[n_dir]   = f_b;
          dir_rnd[n_dir] = f_rnd;
          dir_exp[n_dir] = f_exp;
          n_dir++;
        end else if (n_fields > 0) begin
          other_count++;
          $display("vector line not used: %s", line);
        end
      end
      $fclose(fd);
    end

    // at most two cycles per operation when gaps are inserted
    cycle_limit = RESET_CYCLES + (n_dir + RAND_COUNT) * 2 + LAT_CYCLES + MARGIN;

    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    drive_idle();

    // directed, back to back
    for (int i = 0; i < n_dir; i++) begin
      // file value and model must agree
      check_dst("reference model", model_result(dir_sub[i], dir_a[i], dir_b[i], dir_rnd[i]),
                dir_exp[i]);
      drive_op(dir_sub[i], dir_a[i], dir_b[i], dir_rnd[i], dir_exp[i]);
    end

    // random, some gaps between operations
    for (int i = 0; i < RAND_COUNT; i++) begin
      r_a   = extend_operand($urandom, $urandom_range(0, 1));
      r_b   = extend_operand($urandom, $urandom_range(0, 1));
      r_sub = $urandom_range(0, 1);
      r_rnd = ($urandom_range(0, 3) == 0) ? '0 : round_t'($urandom);
      if ($urandom_range(0, 2) == 0) begin
        drive_idle();
      end
      drive_op(r_sub, r_a, r_b, r_rnd, model_result(r_sub, r_a, r_b, r_rnd));
    end

    // drain, then watch for stray out_vld
    drive_idle();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (LAT_CYCLES + 2) @(negedge clk);
    // let the last falling-edge checks settle first
    #1;

    $display("%0d mismatches, %0d other errors", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/booth_mult_top.sv ====
// Booth multiply-accumulate top
`timescale 1ns/1ps
`default_nettype none

module booth_mult_top
  import booth_mult_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   in_vld,
  input  logic   mult_sub,
  input  round_t mult_round,
  input  src_t   multiplicand,
  input  src_t   multiplier,
  output logic   out_vld,
  output res_t   result_0,
  output res_t   result_1
);

  // aligned rows, ex1 cycle
  dst_t pp_rows [ROW_COUNT];

  // ex1 register to ex2
  ex1_rows_if rows_if ();

  // recoding and row assembly
  booth_pp_gen x_pp_gen (
    .mult_sub     (mult_sub),
    .mult_round   (mult_round),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .pp_rows      (pp_rows)
  );

  // 19 rows to 6, then register
  ex1_tree x_ex1_tree (
    .clk     (clk),
    .reset   (reset),
    .in_vld  (in_vld),
    .pp_rows (pp_rows),
    .rows    (rows_if.stage_out)
  );

  // 6 rows to 2, then register
  ex2_tree x_ex2_tree (
    .clk      (clk),
    .reset    (reset),
    .rows     (rows_if.stage_in),
    .out_vld  (out_vld),
    .result_0 (result_0),
    .result_1 (result_1)
  );

endmodule

`default_nettype wire

// ==== logic/ex2_tree.sv ====
// ex2 compression stage
`timescale 1ns/1ps
`default_nettype none

module ex2_tree
  import booth_mult_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  ex1_rows_if.stage_in  rows,
  output logic          out_vld,
  output res_t          result_0,
  output res_t          result_1
);

  // six rows at 67 bits
  row67_t p2 [EX1_ROWS];
  // level three outputs
  row67_t s2 [2];
  row67_t c2 [2];
  // level four
  row68_t s3;
  row68_t c3;

  // ==================================================
  // level three, 6 rows to 4
  // ==================================================

  // sums sign-extended, carries shifted
  assign p2[0] = {rows.s1_0[DST_WIDTH-1], rows.s1_0};
  assign p2[1] = {rows.c1_0, 1'b0};
  assign p2[2] = {rows.s1_1[DST_WIDTH-1], rows.s1_1};
  assign p2[3] = {rows.c1_1, 1'b0};
  assign p2[4] = {rows.s1_2[DST_WIDTH-1], rows.s1_2};
  assign p2[5] = {rows.c1_2, 1'b0};

  for (genvar k = 0; k < 2; k++) begin : g_l3_csa
    assign s2[k] = p2[3*k] ^ p2[3*k+1] ^ p2[3*k+2];
    assign c2[k] = (p2[3*k]   & p2[3*k+1]) |
                   (p2[3*k]   & p2[3*k+2]) |
                   (p2[3*k+1] & p2[3*k+2]);
  end

  // ==================================================
  // level four, 4 rows to 2
  // ==================================================
  compress_4to2 #(
    .WIDTH (DST_WIDTH+2)
  ) x_l4_comp (
    .in0   ({s2[0][DST_WIDTH], s2[0]}),
    .in1   ({c2[0], 1'b0}),
    .in2   ({s2[1][DST_WIDTH], s2[1]}),
    .in3   ({c2[1], 1'b0}),
    .sum   (s3),
    .carry (c3)
  );

  // ==================================================
  // output register
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= rows.vld;
    end
  end

  // carry row shifted into place here
  always_ff @(posedge clk) begin
    if (rows.vld) begin
      result_0 <= {s3[DST_WIDTH+1], s3};
      result_1 <= {c3[DST_WIDTH+1], c3[DST_WIDTH:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// ==== logic/ex1_tree.sv ====
// ex1 compression stage
`timescale 1ns/1ps
`default_nettype none

module ex1_tree
  import booth_mult_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           in_vld,
  input  dst_t           pp_rows [ROW_COUNT],
  ex1_rows_if.stage_out  rows
);

  // level one outputs, carries unshifted
  dst_t s0 [EX1_ROWS];
  dst_t c0 [EX1_ROWS];
  // level two outputs
  dst_t s1 [EX1_ROWS/2];
  dst_t c1 [EX1_ROWS/2];

  // ==================================================
  // level one, 19 rows to 12
  // ==================================================

  // accumulate, digit 0, digit 1, round row
  compress_4to2 #(
    .WIDTH (DST_WIDTH)
  ) x_l1_comp (
    .in0   (pp_rows[0]),
    .in1   (pp_rows[1]),
    .in2   (pp_rows[2]),
    .in3   (pp_rows[ROW_COUNT-1]),
    .sum   (s0[0]),
    .carry (c0[0])
  );

  // remaining digits in groups of three
  for (genvar k = 1; k < EX1_ROWS; k++) begin : g_l1_csa
    assign s0[k] = pp_rows[3*k] ^ pp_rows[3*k+1] ^ pp_rows[3*k+2];
    assign c0[k] = (pp_rows[3*k]   & pp_rows[3*k+1]) |
                   (pp_rows[3*k]   & pp_rows[3*k+2]) |
                   (pp_rows[3*k+1] & pp_rows[3*k+2]);
  end

  // ==================================================
  // level two, 12 rows to 6
  // ==================================================
  for (genvar m = 0; m < EX1_ROWS/2; m++) begin : g_l2
    // carries move up one column here
    compress_4to2 #(
      .WIDTH (DST_WIDTH)
    ) x_l2_comp (
      .in0   (s0[2*m]),
      .in1   ({c0[2*m][DST_WIDTH-2:0], 1'b0}),
      .in2   (s0[2*m+1]),
      .in3   ({c0[2*m+1][DST_WIDTH-2:0], 1'b0}),
      .sum   (s1[m]),
      .carry (c1[m])
    );
  end

  // ==================================================
  // ex1 register
  // ==================================================

  // stage valid
  always_ff @(posedge clk) begin
    if (reset) begin
      rows.vld <= 1'b0;
    end else begin
      rows.vld <= in_vld;
    end
  end

  // rows load only with a new operation
  always_ff @(posedge clk) begin
    if (in_vld) begin
      rows.s1_0 <= s1[0];
      rows.c1_0 <= c1[0];
      rows.s1_1 <= s1[1];
      rows.c1_1 <= c1[1];
      rows.s1_2 <= s1[2];
      rows.c1_2 <= c1[2];
    end
  end

endmodule

`default_nettype wire

// ==== logic/booth_pp_gen.sv ====
// Booth partial product generator
`timescale 1ns/1ps
`default_nettype none

module booth_pp_gen
  import booth_mult_pkg::*;
(
  input  logic   mult_sub,
  input  round_t mult_round,
  input  src_t   multiplicand,
  input  src_t   multiplier,
  output dst_t   pp_rows [ROW_COUNT]
);

  // conditioned multiplier
  src_t               mult_src;
  // sign, multiplier and trailing zero
  logic [SRC_WIDTH+1:0] code_str;

  // per-digit encoder outputs
  pp_t                prod [PP_COUNT];
  hot_t               h    [PP_COUNT];
  logic [PP_COUNT-1:0] sn;

  // ==================================================
  // multiplier conditioning
  // ==================================================

  // subtract: ~b = -b-1, the missing -a comes back as row 0
  assign mult_src = mult_sub ? ~multiplier : multiplier;
  assign code_str = {mult_src[SRC_WIDTH-1], mult_src, 1'b0};

  // ==================================================
  // digit encoders
  // ==================================================
  for (genvar i = 0; i < PP_COUNT; i++) begin : g_digit
    booth_digit_enc x_digit_enc (
      .a       (multiplicand),
      .code    (code_str[2*i+2:2*i]),
      .product (prod[i]),
      .h       (h[i]),
      .sn      (sn[i])
    );
  end

  // ==================================================
  // row assembly
  // ==================================================

  // accumulate row, adds a back in subtract mode
  assign pp_rows[0] = mult_sub ?
                      {{SRC_WIDTH{multiplicand[SRC_WIDTH-1]}}, multiplicand} :
                      '0;

  // digit 0 has no correction below it
  // sign-not then two inverted copies
  assign pp_rows[1] = {{(DST_WIDTH-SRC_WIDTH-3){1'b0}},
                       sn[0], {2{~sn[0]}}, prod[0]};

  // digits 1..16, two columns per index
  for (genvar i = 1; i < PP_COUNT; i++) begin : g_row
    // leading one, sign-not, product, previous hot-one
    logic [SRC_WIDTH+3:0] field;

    assign field = {1'b1, sn[i], prod[i], h[i-1]};
    // leading one of digit 16 falls past bit 65
    assign pp_rows[i+1] = dst_t'(field) << (2 * (i - 1));
  end

  // last hot-one sits just above the round addend
  assign pp_rows[ROW_COUNT-1] = {{(DST_WIDTH-ROUND_WIDTH-2){1'b0}},
                                 h[PP_COUNT-1], mult_round};

endmodule

`default_nettype wire

// ==== logic/booth_digit_enc.sv ====
// Radix-4 Booth digit encoder
`timescale 1ns/1ps
`default_nettype none

module booth_digit_enc
  import booth_mult_pkg::*;
(
  input  src_t        a,
  input  booth_code_t code,
  output pp_t         product,
  output hot_t        h,
  output logic        sn
);

  // multiplicand as 34-bit signed, once and twice
  logic [SRC_WIDTH:0] a_x1;
  logic [SRC_WIDTH:0] a_x2;
  // magnitude picked by the digit
  logic [SRC_WIDTH:0] mag;
  logic               neg;
  // one's complement for negative digits
  logic [SRC_WIDTH:0] sel;

  assign a_x1 = {a[SRC_WIDTH-1], a};
  // fits in 34 bits for 32-bit sources
  assign a_x2 = {a, 1'b0};

  // ==================================================
  // digit decode
  // ==================================================
  always_comb begin
    mag = '0;
    neg = 1'b0;
    case (code)
      3'b001, 3'b010: begin
        mag = a_x1;
      end
      3'b011: begin
        mag = a_x2;
      end
      3'b100: begin
        mag = a_x2;
        neg = 1'b1;
      end
      3'b101, 3'b110: begin
        mag = a_x1;
        neg = 1'b1;
      end
      // 000 and 111 are zero
      default: begin
        mag = '0;
        neg = 1'b0;
      end
    endcase
  end

  assign sel = neg ? ~mag : mag;

  // +1 lands in the low bits of the next row
  assign h       = neg ? 2'b01 : 2'b00;
  assign product = sel[SRC_WIDTH-1:0];
  // sign-not, high for zero and positive picks
  assign sn      = ~sel[SRC_WIDTH];

endmodule

`default_nettype wire

// ==== logic/compress_4to2.sv ====
// 4:2 carry-save compressor
`timescale 1ns/1ps
`default_nettype none

module compress_4to2
  import booth_mult_pkg::*;
#(
  parameter int WIDTH = DST_WIDTH
) (
  input  logic [WIDTH-1:0] in0,
  input  logic [WIDTH-1:0] in1,
  input  logic [WIDTH-1:0] in2,
  input  logic [WIDTH-1:0] in3,
  output logic [WIDTH-1:0] sum,
  output logic [WIDTH-1:0] carry
);

  // internal carry of the first three inputs
  logic [WIDTH-1:0] cout;
  // parity of all four
  logic [WIDTH-1:0] xr;
  // internal carry moved up one column
  logic [WIDTH-1:0] cout_sh;

  assign cout = (in0 & in1) | (in1 & in2) | (in0 & in2);
  assign xr   = (in0 ^ in1) ^ (in2 ^ in3);

  // top bit of cout falls off, result is mod 2^WIDTH
  assign cout_sh = {cout[WIDTH-2:0], 1'b0};

  assign sum   = xr ^ cout_sh;
  // carry has double weight, caller shifts it
  assign carry = (xr & cout_sh) | (~xr & in3);

endmodule

`default_nettype wire

// ==== logic/ex1_rows_if.sv ====
// ex1 to ex2 row bundle
`timescale 1ns/1ps
`default_nettype none

interface ex1_rows_if
  import booth_mult_pkg::*;
  ();

  // three sum/carry pairs left after level two
  // carry rows are not yet shifted
  dst_t s1_0;
  dst_t c1_0;
  dst_t s1_1;
  dst_t c1_1;
  dst_t s1_2;
  dst_t c1_2;
  // one-cycle strobe, rows valid only with it
  logic vld;

  // producer side, ex1 register
  modport stage_out (
    output s1_0, c1_0, s1_1, c1_1, s1_2, c1_2, vld
  );

  // consumer side, ex2 tree
  modport stage_in (
    input s1_0, c1_0, s1_1, c1_1, s1_2, c1_2, vld
  );

endinterface

`default_nettype wire

// ==== logic/booth_mult_pkg.sv ====
// Booth multiplier shared definitions
`default_nettype none

package booth_mult_pkg;

  // ==================================================
  // widths
  // ==================================================

  // operand width, signed 32-bit value extended by one bit
  localparam int SRC_WIDTH   = 33;
  // full product row
  localparam int DST_WIDTH   = 66;
  // unsigned rounding addend
  localparam int ROUND_WIDTH = 32;

  // ==================================================
  // row counts and timing
  // ==================================================

  // one radix-4 digit per bit pair of the multiplier
  localparam int PP_COUNT   = 17;
  // digits plus accumulate row plus round row
  localparam int ROW_COUNT  = 19;
  // rows registered at the end of ex1
  localparam int EX1_ROWS   = 6;
  // in_vld to out_vld
  localparam int LAT_CYCLES = 2;

  // ==================================================
  // vector types
  // ==================================================

  typedef logic [SRC_WIDTH-1:0]   src_t;
  typedef logic [ROUND_WIDTH-1:0] round_t;
  // overlapping window of three multiplier bits
  typedef logic [2:0]             booth_code_t;
  typedef logic [SRC_WIDTH-1:0]   pp_t;
  // plus-one correction for a negated digit
  typedef logic [1:0]             hot_t;
  typedef logic [DST_WIDTH-1:0]   dst_t;
  // ex2 rows grow one bit per level
  typedef logic [DST_WIDTH:0]     row67_t;
  typedef logic [DST_WIDTH+1:0]   row68_t;
  typedef logic [DST_WIDTH+2:0]   res_t;

endpackage

`default_nettype wire
